/* vlog.f */
hw/core_pkg.sv
hw/fetch_sequencer.sv
hw/pc_counter.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/rv_core.sv
test/tb_clock.sv
test/rv_core_assertions.sv
test/tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rv_core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_rv_core -f vlog.f

out=$(./obj_dir/Vtb_rv_core +verilator+error+limit+1000 2>&1 || true)
echo "$out"
echo "$out" | grep -q "^TEST PASS$"

/* test/tb_rv_core.sv */
////////////////////
// rv_core testbench
// imem model, program builder, reference model and compare
////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

    localparam int mem_words = 64;
    localparam int n_random = 400;
    localparam int directed_max = 32;  // longest directed program
    localparam logic [31:0] seed = 32'd36;
    // two cycles per instruction, plus reset per test and some slack
    localparam int max_cycles = 2 * (5 * directed_max + n_random) + 6 * 14 + 100;

    logic               clk;
    logic               reset;
    logic               restart = 1'b0;
    logic               imem_req;
    core_pkg::word_t    imem_addr;
    core_pkg::word_t    imem_rdata = '0;
    logic               retire;
    core_pkg::word_t    retire_pc;
    logic               retire_we;
    core_pkg::reg_idx_t retire_rd;
    core_pkg::word_t    retire_wdata;

    core_pkg::word_t mem [mem_words];
    core_pkg::word_t model_regs [32];
    core_pkg::word_t model_pc;
    logic [31:0]     lfsr_state;
    int              wr_pos;
    logic            checking = 1'b0;
    int              target = 0;
    int              retired = 0;
    int              test_num = 0;
    int              test_errors = 0;
    int              total_errors = 0;
    int              tests_failed = 0;

    tb_clock u_tb_clock (
        .restart (restart),
        .clk     (clk),
        .reset   (reset)
    );

    rv_core #(
        .reset_pc (32'h0)
    ) u_rv_core (
        .clk          (clk),
        .reset        (reset),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .retire       (retire),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata)
    );

    // one cycle read latency
    always @(posedge clk) begin : imem_model
        logic [5:0] fetch_idx;
        if (imem_req) begin
            fetch_idx = imem_addr[7:2];
            #1 imem_rdata = mem[fetch_idx];
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic core_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, core_pkg::op_reg};
    endfunction

    function automatic core_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic core_pkg::word_t addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                                  input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, core_pkg::op_imm};
    endfunction

    function automatic core_pkg::word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                               input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic core_pkg::word_t b_type(input logic [12:0] off, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], core_pkg::op_branch};
    endfunction

    function automatic core_pkg::word_t j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, core_pkg::op_jal};
    endfunction

    function automatic core_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                                input logic is_reg, input core_pkg::word_t x,
                                                input core_pkg::word_t y);
        logic [4:0] sh;
        sh = y[4:0];
        case (f3)
            3'd0:    return (is_reg && alt) ? x - y : x + y;  // no subi
            3'd1:    return x << sh;
            3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3:    return (x < y) ? 32'd1 : 32'd0;
            3'd4:    return x ^ y;
            3'd5:    return alt ? core_pkg::word_t'($signed(x) >>> sh) : x >> sh;
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input core_pkg::word_t x,
                                        input core_pkg::word_t y);
        case (f3)
            3'd0:    return x == y;
            3'd1:    return x != y;
            3'd4:    return $signed(x) < $signed(y);
            3'd5:    return $signed(x) >= $signed(y);
            3'd6:    return x < y;
            3'd7:    return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    // one architectural step, a and b are x[rs1] and x[rs2]
    function automatic void ref_step(input core_pkg::word_t pc, input core_pkg::word_t inst,
                                     input core_pkg::word_t a, input core_pkg::word_t b,
                                     output core_pkg::word_t next_pc, output logic we,
                                     output logic [4:0] rd, output core_pkg::word_t val);
        core_pkg::word_t imm_i;
        core_pkg::word_t imm_b;
        core_pkg::word_t imm_u;
        core_pkg::word_t imm_j;
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u = {inst[31:12], 12'h000};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        rd = inst[11:7];
        next_pc = pc + 32'd4;
        we = 1'b1;
        val = '0;
        case (inst[6:0])
            core_pkg::op_reg:   val = alu_ref(inst[14:12], inst[30], 1'b1, a, b);
            core_pkg::op_imm:   val = alu_ref(inst[14:12], inst[30], 1'b0, a, imm_i);
            core_pkg::op_lui:   val = imm_u;
            core_pkg::op_auipc: val = pc + imm_u;
            core_pkg::op_jal: begin
                val = pc + 32'd4;
                next_pc = pc + imm_j;
            end
            core_pkg::op_jalr: begin
                val = pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            core_pkg::op_branch: begin
                we = 1'b0;
                if (branch_ref(inst[14:12], a, b))
                    next_pc = pc + imm_b;
            end
            default: we = 1'b0;  // unsupported, nop
        endcase
        if (rd == 5'd0)
            we = 1'b0;
    endfunction

    task automatic mismatch(input string what, input core_pkg::word_t got,
                            input core_pkg::word_t exp);
        $display("Error at %0t ns: test %0d retire %0d %s is %h, expected %h",
                 $time, test_num, retired, what, got, exp);
        test_errors++;
    endtask

    always @(negedge clk) begin : compare
        core_pkg::word_t inst;
        core_pkg::word_t exp_next;
        core_pkg::word_t exp_val;
        logic            exp_we;
        logic [4:0]      exp_rd;
        if (reset) begin
            model_pc = 32'h0;
            for (int i = 0; i < 32; i++)
                model_regs[i[4:0]] = '0;
            retired = 0;
            test_errors = 0;
        end else if (checking && imem_req) begin
            // fetch address is the next architectural pc
            if (imem_addr !== model_pc)
                mismatch("imem_addr", imem_addr, model_pc);
        end else if (checking && retire) begin
            inst = mem[model_pc[7:2]];
            ref_step(model_pc, inst, model_regs[inst[19:15]], model_regs[inst[24:20]],
                     exp_next, exp_we, exp_rd, exp_val);
            if (retire_pc !== model_pc)
                mismatch("retire_pc", retire_pc, model_pc);
            if (retire_we !== exp_we)
                mismatch("retire_we", {31'b0, retire_we}, {31'b0, exp_we});
            if (retire_rd !== exp_rd)
                mismatch("retire_rd", {27'b0, retire_rd}, {27'b0, exp_rd});
            if (exp_we && retire_wdata !== exp_val)
                mismatch("retire_wdata", retire_wdata, exp_val);
            if (exp_we)
                model_regs[exp_rd] = exp_val;
            model_pc = exp_next;
            retired++;
        end
    end

    task automatic put(input core_pkg::word_t w);
        mem[wr_pos[5:0]] = w;
        wr_pos++;
    endtask

    // filler depends on the whole word index
    task automatic load_fill();
        for (int i = 0; i < mem_words; i++)
            mem[i[5:0]] = addi_word(i[4:0], 5'd0, {6'b0, i[5:0]});
        wr_pos = 0;
    endtask

    task automatic branch_pair(input logic [2:0] f3, input logic [4:0] t1, input logic [4:0] t2,
                               input logic [4:0] n1, input logic [4:0] n2);
        put(b_type(13'd8, t2, t1, f3));  // taken, skips the marker
        put(addi_word(5'd10, 5'd10, 12'd1));
        put(b_type(13'd8, n2, n1, f3));
        put(addi_word(5'd10, 5'd10, 12'd1));
    endtask

    task automatic random_inst(output core_pkg::word_t w);
        logic [31:0] r;
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        take_bits(3, r);
        kind = r[2:0];
        take_bits(15, r);
        rd = r[4:0];
        rs1 = r[9:5];
        rs2 = r[14:10];
        take_bits(3, r);
        f3 = r[2:0];
        take_bits(1, r);
        alt = r[0];
        take_bits(20, r);
        case (kind)
            3'd0: w = r_type((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                             rs2, rs1, f3, rd);
            3'd1, 3'd2: begin
                if (f3 == 3'd1)
                    imm = {7'b0, r[4:0]};
                else if (f3 == 3'd5)
                    imm = {1'b0, alt, 5'b0, r[4:0]};  // srli or srai
                else
                    imm = r[11:0];
                w = i_type(imm, rs1, f3, rd, core_pkg::op_imm);
            end
            3'd3: w = u_type(r[19:0], rd, core_pkg::op_lui);
            3'd4: w = u_type(r[19:0], rd, core_pkg::op_auipc);
            3'd5: begin
                if (f3[2:1] == 2'b01)
                    f3[2] = 1'b1;  // 010 and 011 are not branches
                w = b_type({{3{r[7]}}, r[7:0], 2'b00}, rs2, rs1, f3);
            end
            3'd6: w = j_type({{11{r[7]}}, r[7:0], 2'b00}, rd);
            default: w = i_type(r[11:0], rs1, 3'b000, rd, core_pkg::op_jalr);
        endcase
    endtask

    task automatic run_program(input int num, input string name, input int count);
        wait (reset == 1'b0);
        test_num = num;
        target = count;
        checking = 1'b1;
        wait (retired == target);
        checking = 1'b0;
        if (test_errors == 0) begin
            $display("test %0d %s: passed, %0d retires", num, name, count);
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        @(posedge clk);
        #1 restart = 1'b1;  // core back in reset before the next program
        @(posedge clk);
        #1 restart = 1'b0;
    endtask

    initial begin : watchdog
        #(max_cycles * 100);
        $display("timeout: the core stopped retiring before all tests finished");
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main
        core_pkg::word_t w;
        int              assert_fails;
        lfsr_state = seed;

        load_fill();
        put(u_type(20'h12345, 5'd1, core_pkg::op_lui));
        put(addi_word(5'd1, 5'd1, 12'h678));
        put(u_type(20'hFFFFF, 5'd2, core_pkg::op_lui));
        put(addi_word(5'd2, 5'd2, 12'hFFF));
        put(addi_word(5'd3, 5'd0, 12'h800));
        put(u_type(20'h80000, 5'd4, core_pkg::op_lui));
        put(addi_word(5'd5, 5'd4, 12'h7FF));
        put(u_type(20'h00001, 5'd6, core_pkg::op_auipc));
        run_program(1, "lui/addi constants", wr_pos);

        load_fill();
        put(u_type(20'h80000, 5'd1, core_pkg::op_lui));
        put(addi_word(5'd1, 5'd1, 12'h123));  // negative operand
        put(addi_word(5'd2, 5'd0, 12'd3));
        put(addi_word(5'd3, 5'd0, 12'hFFB));  // -5
        put(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd4));
        put(r_type(7'h20, 5'd3, 5'd2, 3'd0, 5'd5));
        put(r_type(7'h00, 5'd2, 5'd3, 3'd1, 5'd6));
        put(r_type(7'h00, 5'd2, 5'd3, 3'd2, 5'd7));
        put(r_type(7'h00, 5'd2, 5'd3, 3'd3, 5'd8));
        put(r_type(7'h00, 5'd3, 5'd1, 3'd4, 5'd9));
        put(r_type(7'h00, 5'd2, 5'd1, 3'd5, 5'd10));
        put(r_type(7'h20, 5'd2, 5'd1, 3'd5, 5'd11));
        put(r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd12));
        put(r_type(7'h00, 5'd3, 5'd1, 3'd7, 5'd13));
        put(i_type(12'd1, 5'd3, 3'd2, 5'd14, core_pkg::op_imm));
        put(i_type(12'd1, 5'd3, 3'd3, 5'd15, core_pkg::op_imm));
        put(i_type(12'hFFF, 5'd1, 3'd4, 5'd16, core_pkg::op_imm));
        put(i_type(12'h0F0, 5'd2, 3'd6, 5'd17, core_pkg::op_imm));
        put(i_type(12'h7FF, 5'd1, 3'd7, 5'd18, core_pkg::op_imm));
        put(i_type(12'h004, 5'd3, 3'd1, 5'd19, core_pkg::op_imm));
        put(i_type(12'h01C, 5'd1, 3'd5, 5'd20, core_pkg::op_imm));
        put(i_type(12'h404, 5'd1, 3'd5, 5'd21, core_pkg::op_imm));
        run_program(2, "arithmetic", wr_pos);

        // x1 = -1, x2 = x3 = 1
        load_fill();
        put(addi_word(5'd1, 5'd0, 12'hFFF));
        put(addi_word(5'd2, 5'd0, 12'd1));
        put(addi_word(5'd3, 5'd0, 12'd1));
        branch_pair(3'd0, 5'd2, 5'd3, 5'd1, 5'd2);
        branch_pair(3'd1, 5'd1, 5'd2, 5'd2, 5'd3);
        branch_pair(3'd4, 5'd1, 5'd2, 5'd2, 5'd1);
        branch_pair(3'd5, 5'd2, 5'd1, 5'd1, 5'd2);
        branch_pair(3'd6, 5'd2, 5'd1, 5'd1, 5'd2);
        branch_pair(3'd7, 5'd1, 5'd2, 5'd2, 5'd1);
        run_program(3, "branches", 21);

        load_fill();
        put(j_type(21'd8, 5'd5));
        put(addi_word(5'd10, 5'd10, 12'd1));
        put(addi_word(5'd6, 5'd0, 12'd21));  // odd jalr target
        put(i_type(12'd0, 5'd6, 3'd0, 5'd7, core_pkg::op_jalr));
        put(addi_word(5'd10, 5'd10, 12'd1));
        put(addi_word(5'd0, 5'd0, 12'd5));
        put(j_type(21'd8, 5'd0));
        put(addi_word(5'd10, 5'd10, 12'd1));
        put(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd8));
        put(i_type(12'd40, 5'd5, 3'd0, 5'd9, core_pkg::op_jalr));
        put(addi_word(5'd10, 5'd10, 12'd1));
        put(addi_word(5'd11, 5'd0, 12'd1));
        run_program(4, "jal and jalr", 8);

        load_fill();
        put(addi_word(5'd1, 5'd0, 12'd7));
        put(32'h0000_2283);  // load
        put(32'h0050_2023);  // store
        put(32'h0000_0073);
        put(32'h3000_2573);  // csr read
        put(32'hFFFF_FFFF);
        put(r_type(7'h00, 5'd0, 5'd1, 3'd0, 5'd2));
        run_program(5, "unsupported opcodes", wr_pos);

        load_fill();
        for (int i = 0; i < mem_words; i++) begin
            random_inst(w);
            put(w);
        end
        run_program(6, "random program", n_random);

        assert_fails = u_rv_core.u_rv_core_assertions.fail_count;
        $display("6 tests, %0d failed, %0d errors, %0d assertion failures",
                 tests_failed, total_errors, assert_fails);
        if (tests_failed == 0 && assert_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/rv_core_assertions.sv */
////////////////////
// core strobe checks
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rv_core_assertions (
    input wire                clk,
    input wire                reset,
    input wire                imem_req,
    input wire                retire,
    input wire                retire_we,
    input core_pkg::reg_idx_t retire_rd
);

    int fail_count = 0;  // read by the testbench at the end

    req_retire_apart: assert property (@(posedge clk) disable iff (reset)
        !(imem_req && retire))
    else begin
        fail_count++;
        $error("imem_req and retire high in the same cycle");
    end

    // fixed two cycle instruction
    req_then_retire: assert property (@(posedge clk) disable iff (reset)
        imem_req |=> retire)
    else begin
        fail_count++;
        $error("imem_req not followed by retire");
    end

    no_x0_write: assert property (@(posedge clk) disable iff (reset)
        retire_we |-> (retire_rd != 5'd0))
    else begin
        fail_count++;
        $error("retire_we reported for x0");
    end

endmodule

bind rv_core rv_core_assertions u_rv_core_assertions (
    .clk       (clk),
    .reset     (reset),
    .imem_req  (imem_req),
    .retire    (retire),
    .retire_we (retire_we),
    .retire_rd (retire_rd)
);

`default_nettype wire

/* test/tb_clock.sv */
////////////////////
// testbench clock
// 100 ns clock, reset held for 10 cycles
////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    input  wire  restart,  // rising edge starts another reset
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;  // released just after the edge
        @(posedge restart);
    end

endmodule

`default_nettype wire

/* hw/rv_core.sv */
////////////////////
// rv32i core top
// one instruction per two cycles, no pipeline
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
    parameter core_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  wire                clk,
    input  wire                reset,
    output logic               imem_req,
    output core_pkg::word_t    imem_addr,
    input  core_pkg::word_t    imem_rdata,  // valid the cycle after imem_req
    output logic               retire,
    output core_pkg::word_t    retire_pc,
    output logic               retire_we,
    output core_pkg::reg_idx_t retire_rd,
    output core_pkg::word_t    retire_wdata
);

    logic                fetch;
    logic                execute;
    core_pkg::word_t     pc;
    logic                jump_en;
    core_pkg::word_t     jump_target;
    core_pkg::inst_fmt_t fmt;
    core_pkg::alu_op_t   alu_op;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    core_pkg::reg_idx_t  rd;
    core_pkg::reg_idx_t  rs1;
    core_pkg::reg_idx_t  rs2;
    core_pkg::word_t     imm;
    core_pkg::word_t     rs1_data;
    core_pkg::word_t     rs2_data;
    logic                rd_we;
    core_pkg::word_t     rd_wdata;
    logic                reg_we;

    assign reg_we = execute && rd_we;  // write only in the execute cycle

    fetch_sequencer u_fetch_sequencer (
        .clk     (clk),
        .reset   (reset),
        .fetch   (fetch),
        .execute (execute)
    );

    pc_counter #(
        .reset_pc (reset_pc)
    ) u_pc_counter (
        .clk         (clk),
        .reset       (reset),
        .advance     (execute),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc)
    );

    inst_decoder u_inst_decoder (
        .inst   (imem_rdata),
        .fmt    (fmt),
        .alu_op (alu_op),
        .opcode (opcode),
        .funct3 (funct3),
        .rd     (rd),
        .rs1    (rs1),
        .rs2    (rs2),
        .imm    (imm)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .we     (reg_we),
        .waddr  (rd),
        .wdata  (rd_wdata),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    exec_unit u_exec_unit (
        .fmt         (fmt),
        .alu_op      (alu_op),
        .opcode      (opcode),
        .funct3      (funct3),
        .rd          (rd),
        .imm         (imm),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rd_we       (rd_we),
        .rd_wdata    (rd_wdata),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

    assign imem_req  = fetch;
    assign imem_addr = pc;

    // retire report
    assign retire       = execute;
    assign retire_pc    = pc;
    assign retire_we    = reg_we;
    assign retire_rd    = rd;
    assign retire_wdata = rd_wdata;

endmodule

`default_nettype wire

/* hw/exec_unit.sv */
////////////////////
// execute unit
// alu, branch and jump resolve, write back select
////////////////////
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
    input  core_pkg::inst_fmt_t fmt,
    input  core_pkg::alu_op_t   alu_op,
    input  wire [6:0]           opcode,
    input  wire [2:0]           funct3,
    input  core_pkg::reg_idx_t  rd,
    input  core_pkg::word_t     imm,
    input  core_pkg::word_t     pc,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    output logic                rd_we,
    output core_pkg::word_t     rd_wdata,
    output logic                jump_en,
    output core_pkg::word_t     jump_target
);

    core_pkg::word_t alu_a;
    core_pkg::word_t alu_b;
    core_pkg::word_t alu_res;
    core_pkg::word_t link;
    logic            is_jalr;
    logic            taken;

    assign is_jalr = (opcode == core_pkg::op_jalr);
    assign link    = pc + core_pkg::word_t'(core_pkg::inst_width_bytes);

    // operand select
    always_comb begin
        case (fmt)
            core_pkg::fmt_r: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
            core_pkg::fmt_i: begin
                alu_a = rs1_data;  // op_imm and jalr
                alu_b = imm;
            end
            core_pkg::fmt_u: begin
                alu_a = (opcode == core_pkg::op_lui) ? '0 : pc;
                alu_b = imm;
            end
            core_pkg::fmt_b, core_pkg::fmt_j: begin
                alu_a = pc;  // target = pc + offset
                alu_b = imm;
            end
            default: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
        endcase
    end

    always_comb begin
        case (alu_op)
            core_pkg::alu_add:  alu_res = alu_a + alu_b;
            core_pkg::alu_sub:  alu_res = alu_a - alu_b;
            core_pkg::alu_sll:  alu_res = alu_a << alu_b[4:0];
            core_pkg::alu_slt:  alu_res = {31'b0, $signed(alu_a) < $signed(alu_b)};
            core_pkg::alu_sltu: alu_res = {31'b0, alu_a < alu_b};
            core_pkg::alu_xor:  alu_res = alu_a ^ alu_b;
            core_pkg::alu_srl:  alu_res = alu_a >> alu_b[4:0];
            core_pkg::alu_sra:  alu_res = $signed(alu_a) >>> alu_b[4:0];
            core_pkg::alu_or:   alu_res = alu_a | alu_b;
            core_pkg::alu_and:  alu_res = alu_a & alu_b;
            default:            alu_res = '0;
        endcase
    end

    // branch compare on register values, alu is busy with the target
    always_comb begin
        case (funct3)
            3'b000:  taken = (rs1_data == rs2_data);                   // beq
            3'b001:  taken = (rs1_data != rs2_data);                   // bne
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));  // blt
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data)); // bge
            3'b110:  taken = (rs1_data < rs2_data);                    // bltu
            3'b111:  taken = (rs1_data >= rs2_data);                   // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign jump_en = (fmt == core_pkg::fmt_j) || is_jalr || ((fmt == core_pkg::fmt_b) && taken);
    assign jump_target = is_jalr ? {alu_res[31:1], 1'b0} : alu_res;

    assign rd_wdata = (fmt == core_pkg::fmt_j || is_jalr) ? link : alu_res;

    // branches and unsupported opcodes write nothing
    assign rd_we = (rd != '0) && (fmt == core_pkg::fmt_r || fmt == core_pkg::fmt_i ||
                                  fmt == core_pkg::fmt_u || fmt == core_pkg::fmt_j);

endmodule

`default_nettype wire

/* hw/reg_file.sv */
////////////////////
// register file
// 32 x 32, two async reads, one write
////////////////////
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire                clk,
    input  wire                reset,
    input  wire                we,
    input  core_pkg::reg_idx_t waddr,
    input  core_pkg::word_t    wdata,
    input  core_pkg::reg_idx_t raddr1,
    input  core_pkg::reg_idx_t raddr2,
    output core_pkg::word_t    rdata1,
    output core_pkg::word_t    rdata2
);

    core_pkg::word_t regs [32];

    // x0 stays zero, the core never writes rd 0
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

/* hw/inst_decoder.sv */
////////////////////
// instruction decoder
// fields, format, immediate and alu op select
////////////////////
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
    input  core_pkg::word_t     inst,
    output core_pkg::inst_fmt_t fmt,
    output core_pkg::alu_op_t   alu_op,
    output logic [6:0]          opcode,
    output logic [2:0]          funct3,
    output core_pkg::reg_idx_t  rd,
    output core_pkg::reg_idx_t  rs1,
    output core_pkg::reg_idx_t  rs2,
    output core_pkg::word_t     imm
);

    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    always_comb begin
        case (opcode)
            core_pkg::op_reg:                     fmt = core_pkg::fmt_r;
            core_pkg::op_imm, core_pkg::op_jalr:  fmt = core_pkg::fmt_i;
            core_pkg::op_branch:                  fmt = core_pkg::fmt_b;
            core_pkg::op_lui, core_pkg::op_auipc: fmt = core_pkg::fmt_u;
            core_pkg::op_jal:                     fmt = core_pkg::fmt_j;
            default:                              fmt = core_pkg::fmt_none;
        endcase
    end

    // sign extended immediates, bit 31 is always the sign
    always_comb begin
        case (fmt)
            core_pkg::fmt_i: imm = {{20{inst[31]}}, inst[31:20]};
            core_pkg::fmt_b: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            core_pkg::fmt_u: imm = {inst[31:12], 12'b0};
            core_pkg::fmt_j: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:         imm = '0;
        endcase
    end

    always_comb begin
        alu_op = core_pkg::alu_add;  // address and link math
        if (opcode == core_pkg::op_reg || opcode == core_pkg::op_imm) begin
            case (funct3)
                3'b000: begin
                    // immediate form has no subi, funct7 is part of imm there
                    if (opcode == core_pkg::op_reg && funct7[5])
                        alu_op = core_pkg::alu_sub;
                end
                3'b001:  alu_op = core_pkg::alu_sll;
                3'b010:  alu_op = core_pkg::alu_slt;
                3'b011:  alu_op = core_pkg::alu_sltu;
                3'b100:  alu_op = core_pkg::alu_xor;
                3'b101:  alu_op = funct7[5] ? core_pkg::alu_sra : core_pkg::alu_srl;
                3'b110:  alu_op = core_pkg::alu_or;
                default: alu_op = core_pkg::alu_and;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/pc_counter.sv */
////////////////////
// pc counter
// program counter with step and jump load
////////////////////
`timescale 1ns/10ps
`default_nettype none

module pc_counter #(
    parameter core_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  wire             clk,
    input  wire             reset,
    input  wire             advance,      // end of execute cycle
    input  wire             jump_en,
    input  core_pkg::word_t jump_target,
    output core_pkg::word_t pc
);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (advance) begin
            if (jump_en)
                pc <= jump_target;
            else
                pc <= pc + core_pkg::word_t'(core_pkg::inst_width_bytes);
        end
    end

endmodule

`default_nettype wire

/* hw/fetch_sequencer.sv */
////////////////////
// fetch sequencer
// alternates fetch and execute cycles
////////////////////
`timescale 1ns/10ps
`default_nettype none

module fetch_sequencer (
    input  wire  clk,
    input  wire  reset,
    output logic fetch,
    output logic execute
);

    typedef enum logic {
        fetch_state,
        exec_state
    } seq_state_t;

    seq_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetch_state;
        end else begin
            // one instruction in flight, so just toggle
            state <= (state == fetch_state) ? exec_state : fetch_state;
        end
    end

    assign fetch   = (state == fetch_state) && !reset;  // no request while held in reset
    assign execute = (state == exec_state);

endmodule

`default_nettype wire

/* hw/core_pkg.sv */
////////////////////
// core package
// shared widths, opcodes and decode enums for the rv32i core
////////////////////
`default_nettype none

package core_pkg;

    localparam int xlen = 32;
    localparam int inst_width_bytes = 4;  // pc step

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // instruction format, also selects immediate layout
    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_none  // unsupported opcode, retires as nop
    } inst_fmt_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

endpackage

`default_nettype wire
